//--- include/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// ====================
// register file sizes
// ====================
`define ARF_SIZE	32	// architectural regs
`define PRF_SIZE	64	// physical regs

// ====================
// queue depths
// ====================
`define ROB_DEPTH	16	// reorder buffer slots
`define FL_DEPTH	32	// PRF_SIZE - ARF_SIZE, regs free after reset

// never renamed, never gets a physical reg
`define ZERO_REG	31

`endif

//--- hw/rename_pkg.sv
`default_nettype none

`include "rename_cfg.svh"

package rename_pkg;

	// index widths follow the sizes in the cfg header
	typedef logic [$clog2(`ARF_SIZE)-1:0]	areg_t;		// arch reg, 5b
	typedef logic [$clog2(`PRF_SIZE)-1:0]	preg_t;		// phys reg, 6b
	typedef logic [$clog2(`ROB_DEPTH)-1:0]	rob_idx_t;	// rob slot, 4b

	// extra msb is the lap bit for full/empty detection
	typedef logic [$clog2(`FL_DEPTH):0]		fl_ptr_t;

	// halt sequence
	typedef enum logic [1:0] {
		RUN		= 2'b00,	// normal dispatch
		DRAIN	= 2'b01,	// halt accepted, waiting for it to retire
		HALTED	= 2'b10		// halt retired, core stopped
	} core_state_e;

endpackage : rename_pkg

`default_nettype wire

//--- hw/dispatch_if.sv
`timescale 1ns/10ps
`default_nettype none

// one dispatch event, shared by ctrl, free list, map table and rob
interface dispatch_if;
	import rename_pkg::*;

	logic	dispatch_en;	// instr accepted this cycle
	logic	alloc_en;		// accepted and needs a new phys reg
	areg_t	dest_areg;		// arch destination
	logic	is_halt;		// accepted instr is a halt
	preg_t	new_preg;		// free list head
	preg_t	old_preg;		// current mapping of dest_areg

	modport ctrl (output dispatch_en, output alloc_en, output dest_areg, output is_halt);

	modport fl (input alloc_en, output new_preg);

	modport map (input dispatch_en, input alloc_en, input dest_areg, input new_preg,
		output old_preg);

	modport rob (input dispatch_en, input alloc_en, input dest_areg, input is_halt,
		input new_preg, input old_preg);

endinterface : dispatch_if

`default_nettype wire

//--- hw/dispatch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module dispatch_ctrl (
	input	logic				clk,
	input	logic				rst_n_i,
	input	logic				id_valid_i,		// decoded instr present
	input	logic				id_halt_i,
	input	rename_pkg::areg_t	id_dest_i,
	input	logic				rob_full_i,
	input	logic				retire_halt_i,	// halt leaving the rob
	dispatch_if.ctrl			disp,
	output	logic				halted_o
);
	import rename_pkg::*;

	core_state_e	state_q;
	core_state_e	state_d;
	logic			accept;

	// free list never runs dry so only the rob can stall us
	assign accept = (state_q == RUN) && !rob_full_i && id_valid_i;

	assign disp.dispatch_en	= accept;
	assign disp.alloc_en	= accept && !id_halt_i && (id_dest_i != areg_t'(`ZERO_REG));
	assign disp.dest_areg	= id_dest_i;
	assign disp.is_halt		= id_halt_i;

	// ====================
	// halt sequence FSM
	// ====================
	always_comb begin
		state_d = state_q;
		case (state_q)
			RUN:	if (accept && id_halt_i) state_d = DRAIN;	// stop taking instrs
			DRAIN:	if (retire_halt_i) state_d = HALTED;		// older work all retired
			HALTED:	state_d = HALTED;							// stays until reset
			default: state_d = RUN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= RUN;
		end else begin
			state_q <= state_d;
		end
	end

	assign halted_o = (state_q == HALTED);

	// the rob can only retire a halt that was accepted here
	a_halt_retires_in_drain : assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_halt_i |-> (state_q == DRAIN));

endmodule : dispatch_ctrl

`default_nettype wire

//--- hw/map_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module map_table (
	input	logic				clk,
	input	logic				rst_n_i,
	input	rename_pkg::areg_t	ra_i,			// source a
	input	rename_pkg::areg_t	rb_i,			// source b
	input	logic				bcast_vld_i,	// completion wake-up
	input	rename_pkg::preg_t	bcast_preg_i,
	dispatch_if.map				disp,
	output	rename_pkg::preg_t	opa_preg_o,
	output	rename_pkg::preg_t	opb_preg_o,
	output	logic				opa_rdy_o,
	output	logic				opb_rdy_o
);
	import rename_pkg::*;

	preg_t					map_q [`ARF_SIZE];	// arch -> phys
	logic [`PRF_SIZE-1:0]	rdy_q;				// one bit per phys reg
	logic					remap;

	assign remap = disp.dispatch_en && disp.alloc_en;

	// lookups see the table before this cycle's remap, no bypass
	assign opa_preg_o		= map_q[ra_i];
	assign opb_preg_o		= map_q[rb_i];
	assign opa_rdy_o		= rdy_q[opa_preg_o];
	assign opb_rdy_o		= rdy_q[opb_preg_o];
	assign disp.old_preg	= map_q[disp.dest_areg];	// becomes told in the rob

	// identity mapping out of reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `ARF_SIZE; i++)
				map_q[i] <= preg_t'(i);
		end else if (remap) begin
			map_q[disp.dest_areg] <= disp.new_preg;
		end
	end

	// low half of the prf holds committed values, all ready
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdy_q <= {{(`PRF_SIZE - `ARF_SIZE){1'b0}}, {`ARF_SIZE{1'b1}}};
		end else begin
			if (bcast_vld_i)
				rdy_q[bcast_preg_i] <= 1'b1;	// producer finished
			if (remap)
				rdy_q[disp.new_preg] <= 1'b0;	// fresh tag, value pending
		end
	end

endmodule : map_table

`default_nettype wire

//--- hw/free_list.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module free_list (
	input	logic				clk,
	input	logic				rst_n_i,
	dispatch_if.fl				disp,
	input	logic				retire_free_en_i,	// retiring entry frees told
	input	rename_pkg::preg_t	retire_told_i
);
	import rename_pkg::*;

	localparam int IDX_W = $clog2(`FL_DEPTH);	// slot bits, msb of ptr is lap bit

	preg_t		fifo_q [`FL_DEPTH];
	fl_ptr_t	head_q;		// next reg handed out
	fl_ptr_t	tail_q;		// next slot for a freed reg
	logic		empty;
	logic		full;

	assign empty	= (head_q == tail_q);
	assign full		= (head_q[IDX_W] != tail_q[IDX_W]) &&
					  (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0]);

	assign disp.new_preg = fifo_q[head_q[IDX_W-1:0]];	// always offered, popped on alloc

	// ====================
	// pointers
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			head_q <= '0;
			tail_q <= fl_ptr_t'(`FL_DEPTH);	// one lap ahead, list full
		end else begin
			if (disp.alloc_en)
				head_q <= head_q + fl_ptr_t'(1);
			if (retire_free_en_i)
				tail_q <= tail_q + fl_ptr_t'(1);
		end
	end

	// regs above the arch range start out free, in order
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `FL_DEPTH; i++)
				fifo_q[i] <= preg_t'(`ARF_SIZE + i);
		end else if (retire_free_en_i) begin
			fifo_q[tail_q[IDX_W-1:0]] <= retire_told_i;
		end
	end

	// dispatch never checks the list, the sizing must hold
	a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n_i)
		disp.alloc_en |-> !empty);

	// more frees than allocations means a tag leaked twice
	a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n_i)
		retire_free_en_i |-> !full);

endmodule : free_list

`default_nettype wire

//--- hw/rob.sv
`timescale 1ns/10ps
`default_nettype none

`include "rename_cfg.svh"

module rob (
	input	logic					clk,
	input	logic					rst_n_i,
	dispatch_if.rob					disp,

	// completion from the execute side
	input	logic					cmpl_vld_i,
	input	rename_pkg::rob_idx_t	cmpl_idx_i,

	output	rename_pkg::rob_idx_t	rob_idx_o,			// slot for this dispatch
	output	logic					rob_full_o,

	// wake-up for the map table
	output	logic					bcast_vld_o,
	output	rename_pkg::preg_t		bcast_preg_o,

	// retirement
	output	logic					retire_vld_o,
	output	rename_pkg::areg_t		retire_areg_o,
	output	rename_pkg::preg_t		retire_told_o,
	output	logic					retire_free_en_o,	// told goes back to free list
	output	logic					retire_halt_o
);
	import rename_pkg::*;

	// per-entry control
	logic [`ROB_DEPTH-1:0]	vld_q;
	logic [`ROB_DEPTH-1:0]	done_q;

	// per-entry payload, only read while the entry is valid
	logic [`ROB_DEPTH-1:0]	has_dest_q;
	logic [`ROB_DEPTH-1:0]	halt_q;
	areg_t					areg_q [`ROB_DEPTH];
	preg_t					tnew_q [`ROB_DEPTH];
	preg_t					told_q [`ROB_DEPTH];

	rob_idx_t				head_q;		// oldest entry
	rob_idx_t				tail_q;		// next free slot

	// ====================
	// dispatch side
	// ====================
	assign rob_idx_o	= tail_q;
	assign rob_full_o	= vld_q[tail_q];	// tail caught up with a live entry

	always_ff @(posedge clk) begin
		if (disp.dispatch_en) begin
			has_dest_q[tail_q]	<= disp.alloc_en;
			halt_q[tail_q]		<= disp.is_halt;
			areg_q[tail_q]		<= disp.dest_areg;
			tnew_q[tail_q]		<= disp.new_preg;
			told_q[tail_q]		<= disp.old_preg;
		end
	end

	// ====================
	// completion and broadcast
	// ====================
	// no-dest entries complete silently
	assign bcast_vld_o	= cmpl_vld_i && has_dest_q[cmpl_idx_i];
	assign bcast_preg_o	= tnew_q[cmpl_idx_i];

	// ====================
	// in-order retire
	// ====================
	assign retire_vld_o		= vld_q[head_q] && done_q[head_q];	// one per cycle at most
	assign retire_areg_o	= areg_q[head_q];
	assign retire_told_o	= told_q[head_q];
	assign retire_free_en_o	= retire_vld_o && has_dest_q[head_q];
	assign retire_halt_o	= retire_vld_o && halt_q[head_q];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vld_q	<= '0;
			done_q	<= '0;
			head_q	<= '0;
			tail_q	<= '0;
		end else begin
			if (disp.dispatch_en) begin
				vld_q[tail_q]	<= 1'b1;
				done_q[tail_q]	<= disp.is_halt;	// halt has nothing to execute
				tail_q			<= tail_q + rob_idx_t'(1);
			end
			if (cmpl_vld_i)
				done_q[cmpl_idx_i] <= 1'b1;
			if (retire_vld_o) begin
				vld_q[head_q]	<= 1'b0;
				head_q			<= head_q + rob_idx_t'(1);
			end
		end
	end

	// the execute side may only finish live, unfinished work
	a_cmpl_live_entry : assert property (@(posedge clk) disable iff (!rst_n_i)
		cmpl_vld_i |-> vld_q[cmpl_idx_i] && !done_q[cmpl_idx_i]);

endmodule : rob

`default_nettype wire

//--- hw/rename_core.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core (
	input	logic					clk,
	input	logic					rst_n_i,

	// decoded instr
	input	logic					id_valid_i,
	input	logic					id_halt_i,
	input	rename_pkg::areg_t		id_dest_i,
	input	rename_pkg::areg_t		id_ra_i,
	input	rename_pkg::areg_t		id_rb_i,

	// completion by rob index
	input	logic					cmpl_vld_i,
	input	rename_pkg::rob_idx_t	cmpl_rob_idx_i,

	// dispatch results
	output	logic					dispatch_en_o,
	output	rename_pkg::preg_t		dest_preg_o,
	output	rename_pkg::rob_idx_t	rob_idx_o,
	output	rename_pkg::preg_t		opa_preg_o,
	output	logic					opa_rdy_o,
	output	rename_pkg::preg_t		opb_preg_o,
	output	logic					opb_rdy_o,

	// retirement
	output	logic					retire_vld_o,
	output	rename_pkg::areg_t		retire_areg_o,
	output	rename_pkg::preg_t		retire_told_o,
	output	logic					halted_o
);
	import rename_pkg::*;

	dispatch_if	disp_bus ();	// one dispatch event per cycle

	logic	rob_full;		// rob -> ctrl
	logic	retire_halt;
	logic	bcast_vld;		// rob -> map table
	preg_t	bcast_preg;
	logic	retire_free_en;	// rob -> free list
	preg_t	retire_told;

	assign dispatch_en_o	= disp_bus.dispatch_en;
	assign dest_preg_o		= disp_bus.new_preg;	// head of free list
	assign retire_told_o	= retire_told;

	// ====================
	// rename blocks
	// ====================
	dispatch_ctrl u_dispatch_ctrl (.clk, .rst_n_i, .id_valid_i, .id_halt_i, .id_dest_i,
		.rob_full_i(rob_full), .retire_halt_i(retire_halt), .disp(disp_bus), .halted_o);

	map_table u_map_table (.clk, .rst_n_i, .ra_i(id_ra_i), .rb_i(id_rb_i),
		.bcast_vld_i(bcast_vld), .bcast_preg_i(bcast_preg), .disp(disp_bus),
		.opa_preg_o, .opb_preg_o, .opa_rdy_o, .opb_rdy_o);

	free_list u_free_list (.clk, .rst_n_i, .disp(disp_bus),
		.retire_free_en_i(retire_free_en), .retire_told_i(retire_told));

	rob u_rob (.clk, .rst_n_i, .disp(disp_bus), .cmpl_vld_i, .cmpl_idx_i(cmpl_rob_idx_i),
		.rob_idx_o, .rob_full_o(rob_full), .bcast_vld_o(bcast_vld), .bcast_preg_o(bcast_preg),
		.retire_vld_o, .retire_areg_o, .retire_told_o(retire_told),
		.retire_free_en_o(retire_free_en), .retire_halt_o(retire_halt));

endmodule : rename_core

`default_nettype wire

//--- tb/rename_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb;
	import rename_pkg::*;

	localparam int CLK_PERIOD	= 40;
	localparam int RST_CYCLES	= 10;
	localparam int MAX_ROWS		= 128;
	localparam int N_COLS		= 18;	// 7 stimulus + 11 expected

	logic		clk;
	logic		rst_n_i;
	logic		id_valid_i;
	logic		id_halt_i;
	areg_t		id_dest_i;
	areg_t		id_ra_i;
	areg_t		id_rb_i;
	logic		cmpl_vld_i;
	rob_idx_t	cmpl_rob_idx_i;
	logic		dispatch_en_o;
	preg_t		dest_preg_o;
	rob_idx_t	rob_idx_o;
	preg_t		opa_preg_o;
	logic		opa_rdy_o;
	preg_t		opb_preg_o;
	logic		opb_rdy_o;
	logic		retire_vld_o;
	areg_t		retire_areg_o;
	preg_t		retire_told_o;
	logic		halted_o;

	int		rows [MAX_ROWS][N_COLS];	// one golden line per cycle
	int		n_rows = 0;
	logic	loaded = 1'b0;				// starts the watchdog

	rename_core DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ====================
	// error reporting
	// ====================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_preg(input preg_t got, input preg_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic check_areg(input areg_t got, input areg_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic check_rob_idx(input rob_idx_t got, input rob_idx_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	// ====================
	// golden file
	// ====================
	task automatic load_golden();
		int		fd;
		int		cnt;
		int		lineno = 0;
		string	line;
		fd = $fopen("tb/rename_golden.txt", "r");
		if (fd == 0)
			stop_run("golden file tb/rename_golden.txt could not be opened");
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			lineno++;
			if (line.len() < 2 || line.getc(0) == 8'h23)	// blank or column notes
				continue;
			if (n_rows >= MAX_ROWS)
				stop_run("golden file has more lines than the testbench can hold");
			cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				rows[n_rows][0], rows[n_rows][1], rows[n_rows][2], rows[n_rows][3],
				rows[n_rows][4], rows[n_rows][5], rows[n_rows][6], rows[n_rows][7],
				rows[n_rows][8], rows[n_rows][9], rows[n_rows][10], rows[n_rows][11],
				rows[n_rows][12], rows[n_rows][13], rows[n_rows][14], rows[n_rows][15],
				rows[n_rows][16], rows[n_rows][17]);
			if (cnt != N_COLS)
				stop_run($sformatf("golden line %0d is malformed, %0d fields read", lineno, cnt));
			n_rows++;
		end
		$fclose(fd);
		if (n_rows == 0)
			stop_run("golden file holds no stimulus lines");
	endtask

	task automatic drive_row(input int i);
		id_valid_i		= (rows[i][0] != 0);
		id_halt_i		= (rows[i][1] != 0);
		id_dest_i		= areg_t'(rows[i][2]);
		id_ra_i			= areg_t'(rows[i][3]);
		id_rb_i			= areg_t'(rows[i][4]);
		cmpl_vld_i		= (rows[i][5] != 0);
		cmpl_rob_idx_i	= rob_idx_t'(rows[i][6]);
	endtask

	task automatic check_row(input int i);
		string tag;
		tag = $sformatf("row %0d", i);
		check_bit(dispatch_en_o, rows[i][7] != 0, {tag, " dispatch_en"});
		check_preg(dest_preg_o, preg_t'(rows[i][8]), {tag, " dest_preg"});
		check_rob_idx(rob_idx_o, rob_idx_t'(rows[i][9]), {tag, " rob_idx"});
		check_preg(opa_preg_o, preg_t'(rows[i][10]), {tag, " opa_preg"});
		check_bit(opa_rdy_o, rows[i][11] != 0, {tag, " opa_rdy"});
		check_preg(opb_preg_o, preg_t'(rows[i][12]), {tag, " opb_preg"});
		check_bit(opb_rdy_o, rows[i][13] != 0, {tag, " opb_rdy"});
		check_bit(retire_vld_o, rows[i][14] != 0, {tag, " retire_vld"});
		if (rows[i][14] != 0) begin	// areg and told only mean something on retire
			check_areg(retire_areg_o, areg_t'(rows[i][15]), {tag, " retire_areg"});
			check_preg(retire_told_o, preg_t'(rows[i][16]), {tag, " retire_told"});
		end
		check_bit(halted_o, rows[i][17] != 0, {tag, " halted"});
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		rst_n_i			= 1'b0;
		id_valid_i		= 1'b0;
		id_halt_i		= 1'b0;
		id_dest_i		= '0;
		id_ra_i			= '0;
		id_rb_i			= '0;
		cmpl_vld_i		= 1'b0;
		cmpl_rob_idx_i	= '0;
		load_golden();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			drive_row(i);				// on the falling edge
			#(CLK_PERIOD / 2 - 5);		// settle, sample before the rising edge
			check_row(i);
			@(negedge clk);
		end
		$display("All tests passed");
		$finish;
	end

	// run length follows the golden line count
	initial begin
		wait (loaded);
		#(n_rows * 2 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD);
		stop_run("timeout, the golden sequence did not finish in time");
	end

endmodule : rename_core_tb

`default_nettype wire

//--- tb/rename_golden.txt
# stimulus: valid halt dest ra rb cmpl_vld cmpl_idx
# expected: disp_en dest_preg rob_idx opa opa_rdy opb opb_rdy ret_vld ret_areg ret_told halted
1 0 1 2 3 0 0  1 32 0 2 1 3 1 0 0 0 0
1 0 2 1 2 0 0  1 33 1 32 0 2 1 0 0 0 0
1 0 31 31 1 0 0  1 34 2 31 1 32 0 0 0 0 0
1 0 3 1 0 1 0  1 34 3 32 0 0 1 0 0 0 0
0 0 0 1 3 0 0  0 35 4 32 1 34 0 1 1 1 0
0 0 0 31 2 1 2  0 35 4 31 1 33 0 0 0 0 0
0 0 0 2 2 1 1  0 35 4 33 0 33 0 0 0 0 0
0 0 0 2 3 1 3  0 35 4 33 1 34 0 1 2 2 0
0 0 0 3 0 0 0  0 35 4 34 1 0 1 1 31 31 0
0 0 0 0 0 0 0  0 35 4 0 1 0 1 1 3 3 0
1 0 4 0 0 0 0  1 35 4 0 1 0 1 0 0 0 0
1 0 5 0 0 0 0  1 36 5 0 1 0 1 0 0 0 0
1 0 6 0 0 1 5  1 37 6 0 1 0 1 0 0 0 0
1 0 7 0 0 1 6  1 38 7 0 1 0 1 0 0 0 0
1 0 8 0 0 1 7  1 39 8 0 1 0 1 0 0 0 0
1 0 9 0 0 1 8  1 40 9 0 1 0 1 0 0 0 0
1 0 10 0 0 1 9  1 41 10 0 1 0 1 0 0 0 0
1 0 11 0 0 1 10  1 42 11 0 1 0 1 0 0 0 0
1 0 12 0 0 1 11  1 43 12 0 1 0 1 0 0 0 0
1 0 13 0 0 1 12  1 44 13 0 1 0 1 0 0 0 0
1 0 14 0 0 1 13  1 45 14 0 1 0 1 0 0 0 0
1 0 15 0 0 1 14  1 46 15 0 1 0 1 0 0 0 0
1 0 16 0 0 1 15  1 47 0 0 1 0 1 0 0 0 0
1 0 17 0 0 1 0  1 48 1 0 1 0 1 0 0 0 0
1 0 18 0 0 1 1  1 49 2 0 1 0 1 0 0 0 0
1 0 19 0 0 1 2  1 50 3 0 1 0 1 0 0 0 0
1 0 20 0 0 1 4  0 51 4 0 1 0 1 0 0 0 0
1 0 20 0 0 1 3  0 51 4 0 1 0 1 1 4 4 0
1 0 20 0 0 0 0  1 51 4 0 1 0 1 1 5 5 0
1 0 21 0 0 1 4  1 52 5 0 1 0 1 1 6 6 0
1 0 22 0 0 1 5  1 53 6 0 1 0 1 1 7 7 0
1 0 23 0 0 1 6  1 54 7 0 1 0 1 1 8 8 0
1 0 24 0 0 1 7  1 55 8 0 1 0 1 1 9 9 0
1 0 25 0 0 1 8  1 56 9 0 1 0 1 1 10 10 0
1 0 26 0 0 1 9  1 57 10 0 1 0 1 1 11 11 0
1 0 27 0 0 1 10  1 58 11 0 1 0 1 1 12 12 0
1 0 28 0 0 1 11  1 59 12 0 1 0 1 1 13 13 0
1 0 29 0 0 1 12  1 60 13 0 1 0 1 1 14 14 0
1 0 30 0 0 1 13  1 61 14 0 1 0 1 1 15 15 0
1 0 1 0 0 1 14  1 62 15 0 1 0 1 1 16 16 0
1 0 2 0 0 1 15  1 63 0 0 1 0 1 1 17 17 0
1 0 3 0 0 1 0  1 1 1 0 1 0 1 1 18 18 0
1 1 0 0 0 1 1  1 2 2 0 1 0 1 1 19 19 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 20 20 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 21 21 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 22 22 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 23 23 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 24 24 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 25 25 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 26 26 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 27 27 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 28 28 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 29 29 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 30 30 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 1 32 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 2 33 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 3 34 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 1 0 0 0
1 0 5 0 0 0 0  0 2 3 0 1 0 1 0 0 0 1

//--- files.f
+incdir+include
hw/rename_pkg.sv
hw/dispatch_if.sv
hw/dispatch_ctrl.sv
hw/map_table.sv
hw/free_list.sv
hw/rob.sv
hw/rename_core.sv
tb/rename_core_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module rename_core_tb -o sim_rename
	./obj_dir/sim_rename | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
